/* verilog/biu_pkg.sv */
/* Wishbone memory target package
   Bus encodings, widths, memory depth and the stage-to-stage structs */
`default_nettype none

package biu_pkg;

    // Bus widths, 8-bit granularity
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int SEL_WIDTH  = DATA_WIDTH / 8;

    // Memory depth and word index
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;
    localparam int IDX_LSB   = $clog2(SEL_WIDTH);

    // Window size in bytes, as an address-wide limit
    localparam logic [ADDR_WIDTH-1:0] WIN_LIMIT = ADDR_WIDTH'(MEM_WORDS * SEL_WIDTH);

    // Spare request bits, reserved
    localparam int REQ_PAD_W = ADDR_WIDTH - SEL_WIDTH;

    // Cycle type identifier
    typedef enum logic [2:0] {
        CLASSIC      = 3'b000,
        CONST_BURST  = 3'b001,
        INCR_BURST   = 3'b010,
        END_OF_BURST = 3'b111
    } wb_cti_t;

    // Burst type extension
    typedef enum logic [1:0] {
        LINEAR = 2'b00,
        WRAP4  = 2'b01,
        WRAP8  = 2'b10,
        WRAP16 = 2'b11
    } wb_bte_t;

    // Decoded bus request, responder to controller
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic                  eob;
        logic                  burst;
        logic                  in_range;
        logic [SEL_WIDTH-1:0]  sel;
        logic [MEM_AW-1:0]     index;
        logic [DATA_WIDTH-1:0] wdata;
        logic [REQ_PAD_W-1:0]  pad;
    } biu_req_t;

    // Memory command, controller to memory
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [SEL_WIDTH-1:0]  sel;
        logic [MEM_AW-1:0]     index;
        logic [DATA_WIDTH-1:0] wdata;
    } biu_mem_t;

    // Beat response, controller back to bus
    typedef struct packed {
        logic                  done;
        logic [DATA_WIDTH-1:0] rdata;
    } biu_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        BURST,
        DRAIN
    } biu_state_t;

endpackage

`default_nettype wire

/* verilog/biu_responder_wb.sv */
/* Wishbone B4 responder
   Qualifies bus cycles, decodes the address window and builds the request */
`timescale 1ns/1ps
`default_nettype none

module biu_responder_wb #(
    parameter logic [biu_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0
)(
    input  logic                            i_wb_clk,
    input  logic                            i_arst_n,
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    input  logic                            i_wb_we,
    input  biu_pkg::wb_cti_t                i_wb_cti,
    input  biu_pkg::wb_bte_t                i_wb_bte,
    input  logic [biu_pkg::SEL_WIDTH-1:0]   i_wb_sel,
    input  logic [biu_pkg::ADDR_WIDTH-1:0]  i_wb_addr,
    input  logic [biu_pkg::DATA_WIDTH-1:0]  i_wb_data,
    input  biu_pkg::biu_rsp_t               i_rsp,
    output biu_pkg::biu_req_t               o_req,
    output logic                            o_wb_ack,
    output logic [biu_pkg::DATA_WIDTH-1:0]  o_wb_data
);

    logic [biu_pkg::ADDR_WIDTH-1:0] offset;
    logic                           incr_linear;
    logic                           in_burst_q;

    // Byte offset into the window
    // Below base wraps to a large value and fails the limit test
    assign offset = i_wb_addr - BASE_ADDR;

    // Only linear incrementing bursts get prefetch
    // Wrap bursts fall back to single beats at the master's addresses
    assign incr_linear = (i_wb_cti == biu_pkg::INCR_BURST) &&
                         (i_wb_bte == biu_pkg::LINEAR);

    // Open burst tracking, updated on each acknowledged beat
    always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_burst_q <= 1'b0;
        end else if (!i_wb_cyc) begin
            in_burst_q <= 1'b0;
        end else if (i_rsp.done) begin
            in_burst_q <= incr_linear;
        end
    end

    always_comb begin
        o_req.valid    = i_wb_cyc & i_wb_stb;
        o_req.we       = i_wb_we;
        // END_OF_BURST, or a burst closed by a non-incrementing CTI
        o_req.eob      = (i_wb_cti == biu_pkg::END_OF_BURST) | (in_burst_q & ~incr_linear);
        o_req.burst    = incr_linear;
        // Single window check for the whole design
        o_req.in_range = (offset < biu_pkg::WIN_LIMIT);
        o_req.sel      = i_wb_sel;
        o_req.index    = offset[biu_pkg::IDX_LSB +: biu_pkg::MEM_AW];
        o_req.wdata    = i_wb_data;
        o_req.pad      = '0;
    end

    // Response goes straight back to the bus
    assign o_wb_ack  = i_rsp.done;
    assign o_wb_data = i_rsp.rdata;

endmodule

`default_nettype wire

/* verilog/biu_burst_ctrl.sv */
/* Burst controller
   Sequences classic and incrementing-burst beats into memory commands */
`timescale 1ns/1ps
`default_nettype none

module biu_burst_ctrl (
    input  logic                            i_wb_clk,
    input  logic                            i_arst_n,
    input  biu_pkg::biu_req_t               i_req,
    input  logic [biu_pkg::DATA_WIDTH-1:0]  i_rdata,
    output biu_pkg::biu_mem_t               o_mem,
    output biu_pkg::biu_rsp_t               o_rsp
);

    biu_pkg::biu_state_t         state_q;
    biu_pkg::biu_state_t         state_d;
    logic                        issued_q;
    logic                        issued_d;
    logic [biu_pkg::MEM_AW-1:0]  beat_idx_q;
    logic [biu_pkg::MEM_AW-1:0]  beat_idx_d;
    logic                        beat_we_q;
    logic                        beat_we_d;
    logic [biu_pkg::MEM_AW-1:0]  next_idx;
    logic                        match;
    logic                        last;
    logic                        done;
    biu_pkg::biu_mem_t           cmd_cur;
    biu_pkg::biu_mem_t           cmd_next;

    assign next_idx = i_req.index + biu_pkg::MEM_AW'(1);

    // Presented beat is the one prepared last cycle
    assign match = i_req.valid && (i_req.index == beat_idx_q) && (i_req.we == beat_we_q);
    assign last  = i_req.eob || !i_req.burst;

    // Access for the beat on the bus, masked outside the window
    always_comb begin
        cmd_cur.en    = i_req.in_range;
        cmd_cur.we    = i_req.we & i_req.in_range;
        cmd_cur.sel   = i_req.sel;
        cmd_cur.index = i_req.index;
        cmd_cur.wdata = i_req.wdata;
    end

    // Speculative read of the following word
    // Index wraps with the window, out-of-range beats are zeroed anyway
    always_comb begin
        cmd_next.en    = 1'b1;
        cmd_next.we    = 1'b0;
        cmd_next.sel   = '1;
        cmd_next.index = next_idx;
        cmd_next.wdata = i_req.wdata;
    end

    always_comb begin
        state_d    = state_q;
        issued_d   = issued_q;
        beat_idx_d = beat_idx_q;
        beat_we_d  = beat_we_q;
        done       = 1'b0;
        o_mem      = '0;

        case (state_q)
            biu_pkg::IDLE: begin
                if (i_req.valid) begin
                    state_d  = biu_pkg::ACCESS;
                    issued_d = 1'b0;
                end
            end

            biu_pkg::ACCESS: begin
                if (!issued_q) begin
                    // First half, issue the command
                    if (i_req.valid) begin
                        o_mem      = cmd_cur;
                        issued_d   = 1'b1;
                        beat_idx_d = i_req.index;
                        beat_we_d  = i_req.we;
                    end else begin
                        state_d = biu_pkg::IDLE;
                    end
                end else if (match) begin
                    // Second half, acknowledge
                    done     = 1'b1;
                    issued_d = 1'b0;
                    if (last) begin
                        state_d = biu_pkg::DRAIN;
                    end else begin
                        state_d    = biu_pkg::BURST;
                        beat_idx_d = next_idx;
                        if (!i_req.we) begin
                            o_mem = cmd_next;
                        end
                    end
                end else if (i_req.valid) begin
                    // Request changed under us, reissue
                    o_mem      = cmd_cur;
                    beat_idx_d = i_req.index;
                    beat_we_d  = i_req.we;
                end else begin
                    issued_d = 1'b0;
                    state_d  = biu_pkg::IDLE;
                end
            end

            biu_pkg::BURST: begin
                if (match) begin
                    done = 1'b1;
                    // Write beats commit in the cycle they are acknowledged
                    if (i_req.we) begin
                        o_mem = cmd_cur;
                    end
                    if (last) begin
                        state_d = biu_pkg::DRAIN;
                    end else begin
                        beat_idx_d = next_idx;
                        if (!i_req.we) begin
                            o_mem = cmd_next;
                        end
                    end
                end else if (i_req.valid) begin
                    // Prediction missed, two-cycle access
                    o_mem      = cmd_cur;
                    issued_d   = 1'b1;
                    beat_idx_d = i_req.index;
                    beat_we_d  = i_req.we;
                    state_d    = biu_pkg::ACCESS;
                end else begin
                    // STB paused, beat restarts from IDLE
                    state_d = biu_pkg::IDLE;
                end
            end

            biu_pkg::DRAIN: begin
                state_d = biu_pkg::IDLE;
            end

            default: begin
                state_d = biu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= biu_pkg::IDLE;
            issued_q   <= 1'b0;
            beat_idx_q <= '0;
            beat_we_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            issued_q   <= issued_d;
            beat_idx_q <= beat_idx_d;
            beat_we_q  <= beat_we_d;
        end
    end

    // Write acks and out-of-window reads carry zero
    assign o_rsp.done  = done;
    assign o_rsp.rdata = (done && !i_req.we && i_req.in_range) ? i_rdata : '0;

endmodule

`default_nettype wire

/* verilog/biu_sram.sv */
/* Byte-lane on-chip memory
   Per-byte write enables, registered read port with one cycle latency */
`timescale 1ns/1ps
`default_nettype none

module biu_sram (
    input  logic                            i_wb_clk,
    input  biu_pkg::biu_mem_t               i_mem,
    output logic [biu_pkg::DATA_WIDTH-1:0]  o_rdata
);

    logic [biu_pkg::DATA_WIDTH-1:0] mem [biu_pkg::MEM_WORDS];
    logic [biu_pkg::DATA_WIDTH-1:0] rdata_q;
    logic [biu_pkg::DATA_WIDTH-1:0] wr_word;

    // Merge enabled lanes over the stored word, little-endian lanes
    always_comb begin
        wr_word = mem[i_mem.index];
        for (int b = 0; b < biu_pkg::SEL_WIDTH; b++) begin
            if (i_mem.sel[b]) begin
                wr_word[8*b +: 8] = i_mem.wdata[8*b +: 8];
            end
        end
    end

    // Write updates the array only
    always_ff @(posedge i_wb_clk) begin
        if (i_mem.en && i_mem.we) begin
            mem[i_mem.index] <= wr_word;
        end
    end

    // Read data held until the next read
    always_ff @(posedge i_wb_clk) begin
        if (i_mem.en && !i_mem.we) begin
            rdata_q <= mem[i_mem.index];
        end
    end

    assign o_rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/biu_subsys_top.sv */
/* Wishbone memory target top level
   Responder, burst controller and byte-lane memory in a chain */
`timescale 1ns/1ps
`default_nettype none

module biu_subsys_top #(
    parameter logic [biu_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0
)(
    input  logic                            i_wb_clk,
    input  logic                            i_arst_n,
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    input  logic                            i_wb_we,
    input  biu_pkg::wb_cti_t                i_wb_cti,
    input  biu_pkg::wb_bte_t                i_wb_bte,
    input  logic [biu_pkg::SEL_WIDTH-1:0]   i_wb_sel,
    input  logic [biu_pkg::ADDR_WIDTH-1:0]  i_wb_addr,
    input  logic [biu_pkg::DATA_WIDTH-1:0]  i_wb_data,
    output logic                            o_wb_ack,
    output logic [biu_pkg::DATA_WIDTH-1:0]  o_wb_data
);

    // Stage links
    biu_pkg::biu_req_t              req;
    biu_pkg::biu_rsp_t              rsp;
    biu_pkg::biu_mem_t              mem_cmd;
    logic [biu_pkg::DATA_WIDTH-1:0] mem_rdata;

    biu_responder_wb #(
        .BASE_ADDR (BASE_ADDR)
    ) biu_responder_wb_i (
        .i_wb_clk  (i_wb_clk),
        .i_arst_n  (i_arst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_cti  (i_wb_cti),
        .i_wb_bte  (i_wb_bte),
        .i_wb_sel  (i_wb_sel),
        .i_wb_addr (i_wb_addr),
        .i_wb_data (i_wb_data),
        .i_rsp     (rsp),
        .o_req     (req),
        .o_wb_ack  (o_wb_ack),
        .o_wb_data (o_wb_data)
    );

    biu_burst_ctrl biu_burst_ctrl_i (
        .i_wb_clk (i_wb_clk),
        .i_arst_n (i_arst_n),
        .i_req    (req),
        .i_rdata  (mem_rdata),
        .o_mem    (mem_cmd),
        .o_rsp    (rsp)
    );

    biu_sram biu_sram_i (
        .i_wb_clk (i_wb_clk),
        .i_mem    (mem_cmd),
        .o_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
/* Testbench clock and reset source
   Free-running clock, active-low reset held for the first few cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
)(
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release on a falling edge, clear of the DUT sampling edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/biu_subsys_props.sv */
/* Wishbone protocol properties for the memory target
   Bound onto the top level, checks ACK against CYC, STB and CTI */
`timescale 1ns/1ps
`default_nettype none

module biu_subsys_props (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_cyc,
    input  logic             i_stb,
    input  biu_pkg::wb_cti_t i_cti,
    input  logic             i_ack
);

    // ACK only inside a qualified beat
    property p_ack_needs_stb;
        @(posedge i_clk) disable iff (!i_arst_n)
        i_ack |-> (i_cyc && i_stb);
    endproperty

    // Nothing acknowledged right out of reset
    property p_ack_low_after_reset;
        @(posedge i_clk)
        !i_arst_n |=> !i_ack;
    endproperty

    // Classic beat, two-cycle registered feedback
    property p_classic_latency;
        @(posedge i_clk) disable iff (!i_arst_n)
        ($rose(i_cyc && i_stb) && (i_cti == biu_pkg::CLASSIC)) |-> ##2 i_ack;
    endproperty

    // Held STB on a classic cycle gets one ACK only
    property p_classic_single_ack;
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_ack && (i_cti == biu_pkg::CLASSIC)) |=> !i_ack;
    endproperty

    a_ack_needs_stb: assert property (p_ack_needs_stb)
        else $error("ACK asserted without CYC and STB");

    a_ack_low_after_reset: assert property (p_ack_low_after_reset)
        else $error("ACK asserted in the cycle after reset");

    a_classic_latency: assert property (p_classic_latency)
        else $error("classic beat not acknowledged two cycles after STB rose");

    a_classic_single_ack: assert property (p_classic_single_ack)
        else $error("two consecutive ACKs on a classic cycle");

endmodule

bind biu_subsys_top biu_subsys_props biu_subsys_props_i (
    .i_clk    (i_wb_clk),
    .i_arst_n (i_arst_n),
    .i_cyc    (i_wb_cyc),
    .i_stb    (i_wb_stb),
    .i_cti    (i_wb_cti),
    .i_ack    (o_wb_ack)
);

`default_nettype wire

/* dv/tb_biu_subsys.sv */
/* Testbench for the Wishbone memory target
   Drives classic and burst cycles, checks reads against a shadow memory */
`timescale 1ns/1ps
`default_nettype none

module tb_biu_subsys;

    localparam logic [31:0] BASE        = 32'h0000_1000;
    localparam int          ACK_TIMEOUT = 20;
    localparam int unsigned SEED        = 32'h531f6102;

    logic                                 clk;
    logic                                 arst_n;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic                                 wb_we;
    biu_pkg::wb_cti_t                     wb_cti;
    biu_pkg::wb_bte_t                     wb_bte;
    logic [biu_pkg::SEL_WIDTH-1:0]        wb_sel;
    logic [biu_pkg::ADDR_WIDTH-1:0]       wb_addr;
    logic [biu_pkg::DATA_WIDTH-1:0]       wb_data;
    logic                                 wb_ack;
    logic [biu_pkg::DATA_WIDTH-1:0]       wb_rdata;

    // Shadow of the target memory
    logic [31:0] model [biu_pkg::MEM_WORDS];
    int          errs;
    int          tests_ok;
    int          tests_bad;

    tb_clkgen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (3)
    ) tb_clkgen_i (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    biu_subsys_top #(
        .BASE_ADDR (BASE)
    ) biu_subsys_top_i (
        .i_wb_clk  (clk),
        .i_arst_n  (arst_n),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_cti  (wb_cti),
        .i_wb_bte  (wb_bte),
        .i_wb_sel  (wb_sel),
        .i_wb_addr (wb_addr),
        .i_wb_data (wb_data),
        .o_wb_ack  (wb_ack),
        .o_wb_data (wb_rdata)
    );

    // Byte address of a word index inside the window
    function automatic logic [31:0] word_addr(input logic [7:0] idx);
        return BASE + {22'b0, idx, 2'b00};
    endfunction

    // Fill pattern, mixes every address bit
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return (word_addr(idx) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // Little-endian lane merge, lane b is bits 8b+7..8b
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_data(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %0t: %s, got %h expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    // Count falling edges until ACK, bounded
    task automatic wait_ack(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack && cycles < ACK_TIMEOUT);
        if (!wb_ack) begin
            $display("Timeout at %0t: no ACK within %0d cycles for address %h",
                     $time, ACK_TIMEOUT, wb_addr);
            errs++;
        end
    endtask

    // Bus idle, ACK must stay low
    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!wb_ack) else begin
                $display("FAILED %0t: ACK high while STB is low", $time);
                errs++;
            end
        end
    endtask

    // Classic beat, STB optionally held one cycle past ACK
    task automatic single_access(input logic we, input logic [31:0] addr,
                                 input logic [3:0] sel, input logic [31:0] wdata,
                                 output logic [31:0] rdata,
                                 input logic hold_stb = 1'b0);
        int cycles;
        @(posedge clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= we;
        wb_cti  <= biu_pkg::CLASSIC;
        wb_bte  <= biu_pkg::LINEAR;
        wb_sel  <= sel;
        wb_addr <= addr;
        wb_data <= wdata;
        wait_ack(cycles);
        rdata = wb_rdata;
        if (hold_stb) begin
            // Master late to drop STB, the beat is not acknowledged again
            @(negedge clk);
            assert (!wb_ack) else begin
                $display("FAILED %0t: second ACK on a held classic STB", $time);
                errs++;
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        idle_check(1);
    endtask

    // Linear incrementing burst, optional one-cycle STB gap before beat pause_at
    task automatic burst_access(input logic we, input logic [7:0] first, input int beats,
                                input int pause_at, input logic use_fill);
        int          cycles;
        logic [7:0]  idx;
        logic [31:0] data;
        for (int b = 0; b < beats; b++) begin
            idx  = first + biu_pkg::MEM_AW'(b);
            data = use_fill ? fill_word(idx) : $urandom;
            if (b == pause_at) begin
                @(posedge clk);
                wb_stb <= 1'b0;
                @(negedge clk);
                assert (!wb_ack) else begin
                    $display("FAILED %0t: ACK during STB pause at beat %0d", $time, b);
                    errs++;
                end
            end
            @(posedge clk);
            wb_cyc  <= 1'b1;
            wb_stb  <= 1'b1;
            wb_we   <= we;
            if (b == beats - 1) begin
                wb_cti <= biu_pkg::END_OF_BURST;
            end else begin
                wb_cti <= biu_pkg::INCR_BURST;
            end
            wb_bte  <= biu_pkg::LINEAR;
            wb_sel  <= '1;
            wb_addr <= word_addr(idx);
            wb_data <= data;
            wait_ack(cycles);
            // Back-to-back ACKs once the burst is running
            if (b > 0 && b != pause_at) begin
                assert (cycles == 1) else begin
                    $display("FAILED %0t: beat %0d acknowledged after %0d cycles",
                             $time, b, cycles);
                    errs++;
                end
            end
            if (we) begin
                model[idx] = data;
            end else begin
                check_data("burst read", wb_rdata, model[idx]);
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        wb_cti <= biu_pkg::CLASSIC;
        idle_check(2);
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errs);
        end
        errs = 0;
    endtask

    initial begin
        int          n;
        int          len;
        logic [7:0]  idx;
        logic [31:0] data;
        logic [3:0]  sel;
        logic [31:0] rd;
        void'($urandom(SEED));
        errs      = 0;
        tests_ok  = 0;
        tests_bad = 0;
        wb_cyc  <= 1'b0;
        wb_stb  <= 1'b0;
        wb_we   <= 1'b0;
        wb_cti  <= biu_pkg::CLASSIC;
        wb_bte  <= biu_pkg::LINEAR;
        wb_sel  <= '0;
        wb_addr <= '0;
        wb_data <= '0;

        n = 0;
        while (arst_n !== 1'b1 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("Timeout at %0t: reset never released", $time);
            errs++;
        end
        idle_check(4);
        finish_test("reset");

        // Whole array written with the fill pattern, then read back
        burst_access(1'b1, 8'd0, biu_pkg::MEM_WORDS, -1, 1'b1);
        burst_access(1'b0, 8'd0, biu_pkg::MEM_WORDS, -1, 1'b0);
        finish_test("fill");

        repeat (16) begin
            idx  = 8'($urandom_range(255));
            data = $urandom;
            single_access(1'b1, word_addr(idx), 4'hf, data, rd);
            model[idx] = data;
            single_access(1'b0, word_addr(idx), 4'hf, 32'h0, rd, 1'b1);
            check_data("word readback", rd, model[idx]);
        end
        finish_test("full_word");

        repeat (16) begin
            idx  = 8'($urandom_range(255));
            data = $urandom;
            sel  = 4'($urandom);
            single_access(1'b1, word_addr(idx), sel, data, rd);
            model[idx] = merge_lanes(model[idx], data, sel);
            single_access(1'b0, word_addr(idx), 4'hf, 32'h0, rd);
            check_data("byte lane readback", rd, model[idx]);
        end
        finish_test("byte_lanes");

        repeat (4) begin
            len = int'($urandom_range(8, 4));
            idx = 8'($urandom_range(247));
            burst_access(1'b1, idx, len, -1, 1'b0);
            burst_access(1'b0, idx, len, -1, 1'b0);
        end
        finish_test("incr_burst");

        idx = 8'($urandom_range(240));
        burst_access(1'b1, idx, 6, 2, 1'b0);
        burst_access(1'b0, idx, 6, 3, 1'b0);
        finish_test("stb_pause");

        // Below the base, and just past the last word
        data = $urandom;
        single_access(1'b1, BASE - 32'd4, 4'hf, data, rd);
        single_access(1'b1, BASE + 32'(biu_pkg::MEM_WORDS * 4), 4'hf, ~data, rd);
        single_access(1'b0, word_addr(8'd255), 4'hf, 32'h0, rd);
        check_data("last word after stray write", rd, model[255]);
        single_access(1'b0, word_addr(8'd0), 4'hf, 32'h0, rd);
        check_data("first word after stray write", rd, model[0]);
        single_access(1'b0, BASE - 32'd4, 4'hf, 32'h0, rd);
        check_data("read below window", rd, 32'h0);
        single_access(1'b0, BASE + 32'h0001_0000, 4'hf, 32'h0, rd);
        check_data("read above window", rd, 32'h0);
        finish_test("out_of_window");

        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/biu_pkg.sv
verilog/biu_responder_wb.sv
verilog/biu_burst_ctrl.sv
verilog/biu_sram.sv
verilog/biu_subsys_top.sv
dv/tb_clkgen.sv
dv/biu_subsys_props.sv
dv/tb_biu_subsys.sv

/* run.sh */
#!/bin/sh
# Build and run the Wishbone memory target testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_biu_subsys \
    -f tb.f \
    -o tb_biu_subsys

./obj_dir/tb_biu_subsys 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: pass message found in sim.log"
    exit 0
else
    echo "run.sh: pass message missing from sim.log"
    exit 1
fi
